// File: rv_pkg.sv
// Shared RV32I widths, encodings, ALU operations and instruction views, imported by every block
package rv_pkg;

    // Data and instruction width, fixed by the ISA
    localparam int XLEN = 32;
    // Register index width
    localparam int REG_ADDR_W = 5;
    // Shift amount width for RV32
    localparam int SHAMT_W = 5;

    // Major opcodes handled by this subsystem
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111
    } opcode_e;

    // funct3 codes shared by OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct7 values, ALT selects SUB and SRA
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    // ALU operations, PASS_B serves LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // R format, register-register
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // I format, register-immediate
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // U format, upper immediate
    typedef struct packed {
        logic [19:0] imm20;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // One instruction word, read through the view that the opcode picks
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_u;

endpackage

// File: issue_if.sv
// Issue bundle from the decoder to the execute stage, one strobe per instruction
interface issue_if import rv_pkg::*; ();

    // Single-cycle strobe, never refused
    logic                  valid;
    // Operation for the ALU
    alu_op_e               alu_op;
    // Operands, already selected by the decoder
    logic [XLEN-1:0]       opa;
    logic [XLEN-1:0]       opb;
    // Destination register
    logic [REG_ADDR_W-1:0] rd;

    // Decoder side drives the whole bundle
    modport dec (
        output valid,
        output alu_op,
        output opa,
        output opb,
        output rd
    );

    // Execute side only consumes it
    modport exe (
        input valid,
        input alu_op,
        input opa,
        input opb,
        input rd
    );

endinterface

// File: register_file.sv
// Integer register file with two combinational read ports, write bypass and x2 preset at reset
module register_file import rv_pkg::*; #(
    parameter logic [XLEN-1:0] SP_INIT = 32'h0110_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    // Read addresses from the decoder
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    // Write port fed by writeback
    input  logic                  wr_en_i,
    input  logic [REG_ADDR_W-1:0] wr_addr_i,
    input  logic [XLEN-1:0]       wr_data_i,
    // Read data, valid in the same cycle
    output logic [XLEN-1:0]       rs1_data_o,
    output logic [XLEN-1:0]       rs2_data_o
);

    // Storage for x1..x31, x0 is hardwired
    logic [XLEN-1:0] regs [1:31];

    // High when the write port updates a real register this cycle
    logic wr_live;

    assign wr_live = wr_en_i && (wr_addr_i != '0);

    // One read port: zero, bypassed write data or stored value
    function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        logic [XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_live && (wr_addr_i == addr)) begin
            // Fresh result overrides the stale entry
            data = wr_data_i;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

    // Write on the rising edge only
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
            // Stack pointer starts at its preset
            regs[2] <= SP_INIT;
        end else if (wr_live) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

// File: instr_decoder.sv
// Combinational RV32I decoder that reads source registers, builds operands and flags illegal words
module instr_decoder import rv_pkg::*; (
    // Instruction strobe and word
    input  logic                  instr_valid_i,
    input  instr_u                instr_i,
    // Register file read ports
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    // Same-cycle reject strobe
    output logic                  illegal_o,
    // Decoded instruction towards execute
    issue_if.dec                  issue
);

    logic                  legal;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       opa;
    logic [XLEN-1:0]       opb;
    logic [REG_ADDR_W-1:0] rd;
    logic                  imm_sra;

    // Map funct3 to an operation where alt picks SUB or SRA
    function automatic alu_op_e f3_to_op(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // Register addresses sit at the same bits in every format
    assign rs1_addr_o = instr_i.r.rs1;
    assign rs2_addr_o = instr_i.r.rs2;

    // Only a right shift immediate may carry the alt funct7 pattern
    assign imm_sra = (instr_i.i.funct3 == F3_SR) && (instr_i.i.imm12[11:5] == F7_ALT);

    always_comb begin
        legal  = 1'b0;
        alu_op = ALU_ADD;
        opa    = rs1_data_i;
        opb    = rs2_data_i;
        // Destination sits at the same bits in every format
        rd     = instr_i.r.rd;
        case (instr_i.r.opcode)
            OPC_OP: begin
                alu_op = f3_to_op(instr_i.r.funct3, instr_i.r.funct7 == F7_ALT);
                if (instr_i.r.funct7 == F7_BASE) begin
                    legal = 1'b1;
                end else if (instr_i.r.funct7 == F7_ALT) begin
                    // Alt form exists only for SUB and SRA
                    legal = (instr_i.r.funct3 == F3_ADD_SUB) || (instr_i.r.funct3 == F3_SR);
                end
            end
            OPC_OP_IMM: begin
                alu_op = f3_to_op(instr_i.i.funct3, imm_sra);
                // Sign-extended 12-bit immediate
                opb    = {{(XLEN-12){instr_i.i.imm12[11]}}, instr_i.i.imm12};
                case (instr_i.i.funct3)
                    F3_SLL:  legal = (instr_i.i.imm12[11:5] == F7_BASE);
                    F3_SR:   legal = (instr_i.i.imm12[11:5] == F7_BASE) || imm_sra;
                    default: legal = 1'b1;
                endcase
            end
            OPC_LUI: begin
                legal  = 1'b1;
                alu_op = ALU_PASS_B;
                opa    = '0;
                // Upper immediate with the low 12 bits zero
                opb    = {instr_i.u.imm20, 12'b0};
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // Exactly one of the two strobes per instruction
    assign issue.valid  = instr_valid_i && legal;
    assign illegal_o    = instr_valid_i && !legal;
    assign issue.alu_op = alu_op;
    assign issue.opa    = opa;
    assign issue.opb    = opb;
    assign issue.rd     = rd;

endmodule

// File: exec_stage.sv
// Execute stage with the RV32I ALU and the result register that drives writeback
module exec_stage import rv_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    // Decoded instruction from the decoder
    issue_if.exe                  issue,
    // Writeback bundle, one cycle after issue
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    logic [XLEN-1:0]    alu_result;
    logic [SHAMT_W-1:0] shamt;

    // Shifts only look at the low bits of opb
    assign shamt = issue.opb[SHAMT_W-1:0];

    always_comb begin
        case (issue.alu_op)
            ALU_ADD:  alu_result = issue.opa + issue.opb;
            ALU_SUB:  alu_result = issue.opa - issue.opb;
            ALU_SLL:  alu_result = issue.opa << shamt;
            // Signed compare
            ALU_SLT:  alu_result = {{(XLEN-1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
            // Unsigned compare
            ALU_SLTU: alu_result = {{(XLEN-1){1'b0}}, issue.opa < issue.opb};
            ALU_XOR:  alu_result = issue.opa ^ issue.opb;
            ALU_SRL:  alu_result = issue.opa >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA:  alu_result = $unsigned($signed(issue.opa) >>> shamt);
            ALU_OR:   alu_result = issue.opa | issue.opb;
            ALU_AND:  alu_result = issue.opa & issue.opb;
            default:  alu_result = issue.opb;
        endcase
    end

    // Strobe follows issue by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= issue.valid;
        end
    end

    // Result and destination held with the strobe
    always_ff @(posedge clk) begin
        if (issue.valid) begin
            wb_rd_o   <= issue.rd;
            wb_data_o <= alu_result;
        end
    end

endmodule

// File: exec_core.sv
// Top level of the RV32I execute subsystem, instruction strobe in and writeback out
module exec_core import rv_pkg::*; #(
    parameter logic [XLEN-1:0] SP_INIT = 32'h0110_0000
) (
    input  logic                  clk,
    input  logic                  rst,
    // Instruction issue, one cycle strobe
    input  logic                  instr_valid_i,
    input  logic [XLEN-1:0]       instr_i,
    // Reject strobe, same cycle as the instruction
    output logic                  illegal_o,
    // Writeback, one cycle after a legal instruction
    output logic                  wb_valid_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [XLEN-1:0]       wb_data_o
);

    // Register file read path
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;

    // Writeback bundle, shared by the write port and the outputs
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_rd;
    logic [XLEN-1:0]       wb_data;

    // Decoder to execute
    issue_if u_issue ();

    instr_decoder u_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .illegal_o     (illegal_o),
        .issue         (u_issue.dec)
    );

    // Writeback loops back into the write port
    register_file #(
        .SP_INIT (SP_INIT)
    ) u_regfile (
        .clk        (clk),
        .rst        (rst),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wr_en_i    (wb_valid),
        .wr_addr_i  (wb_rd),
        .wr_data_i  (wb_data),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    exec_stage u_exec (
        .clk        (clk),
        .rst        (rst),
        .issue      (u_issue.exe),
        .wb_valid_o (wb_valid),
        .wb_rd_o    (wb_rd),
        .wb_data_o  (wb_data)
    );

    assign wb_valid_o = wb_valid;
    assign wb_rd_o    = wb_rd;
    assign wb_data_o  = wb_data;

endmodule

// File: exec_core_sva.sv
// Assertions on exec_core strobe timing and reset state, attached to the DUT with bind
module exec_core_sva (
    input logic clk,
    input logic rst,
    input logic instr_valid_i,
    input logic illegal_o,
    input logic wb_valid_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // Failed assertions, summed into the testbench report
    int fail_count = 0;

    // Legal instruction gives writeback exactly one cycle later
    a_wb_after_issue: assert property (@(posedge clk) disable iff (rst)
        (instr_valid_i && !illegal_o) |=> wb_valid_o)
        else begin
            fail_count++;
            $error("wb_valid_o missing one cycle after a legal instruction");
        end

    // No writeback without a legal instruction the cycle before
    a_wb_has_issue: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o |-> $past(instr_valid_i && !illegal_o))
        else begin
            fail_count++;
            $error("wb_valid_o without a legal instruction one cycle before");
        end

    a_illegal_needs_valid: assert property (@(posedge clk) illegal_o |-> instr_valid_i)
        else begin
            fail_count++;
            $error("illegal_o high without instr_valid_i");
        end

    // Second reset cycle on, both strobes stay low
    a_quiet_in_reset: assert property (@(posedge clk)
        (rst && $past(rst)) |-> (!wb_valid_o && !illegal_o))
        else begin
            fail_count++;
            $error("strobe high during reset");
        end

endmodule

bind exec_core exec_core_sva u_sva (
    .clk           (clk),
    .rst           (rst),
    .instr_valid_i (instr_valid_i),
    .illegal_o     (illegal_o),
    .wb_valid_o    (wb_valid_o)
);

// File: tb_exec_core.sv
// Random-stimulus testbench for exec_core, checks writeback and illegal strobes against a register model
module tb_exec_core import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam logic [XLEN-1:0] SP_VAL = 32'h0FFE_7F00;
    localparam int N_RANDOM = 2000;
    localparam int N_CHAIN = 200;
    localparam int N_ZERO = 100;
    localparam int N_ILLEGAL = 300;
    // Random phase idles up to three cycles after each instruction
    localparam int TEST_CYCLES = 16 + 32 + 4 * N_RANDOM + N_CHAIN + 2 * N_ZERO + 2 * N_ILLEGAL + 8;

    // One expected writeback
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_exp_t;

    logic                  clk;
    logic                  rst;
    logic                  instr_valid_i;
    logic [XLEN-1:0]       instr_i;
    logic                  illegal_o;
    logic                  wb_valid_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;
    logic [XLEN-1:0]       wb_data_o;

    // Architectural state after every issued instruction
    logic [XLEN-1:0] model_regs [32];
    wb_exp_t         wb_q [$];
    wb_exp_t         wb_exp;
    // Expectations for the cycle being driven, and writeback due in this cycle
    logic            cur_legal;
    logic            cur_illegal;
    logic            wb_due;
    int              err_count = 0;
    int              check_count = 0;

    exec_core #(
        .SP_INIT (SP_VAL)
    ) u_dut (
        .clk           (clk),
        .rst           (rst),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .illegal_o     (illegal_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog, worst-case stimulus length plus margin
    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", TEST_CYCLES + 100);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        check_count++;
        if (act !== exp) begin
            $display("error %0t %s expected %h actual %h", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_rd(input string name, input logic [REG_ADDR_W-1:0] exp,
                            input logic [REG_ADDR_W-1:0] act);
        check_count++;
        if (act !== exp) begin
            $display("error %0t %s expected %0d actual %0d", $time, name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            $display("error %0t %s expected %b actual %b", $time, name, exp, act);
            err_count++;
        end
    endtask

    // RV32I subset rules, returns legality with the destination and result
    function automatic logic model_exec(input instr_u w, output logic [REG_ADDR_W-1:0] rd,
                                        output logic [XLEN-1:0] res);
        logic [XLEN-1:0]        a;
        logic [XLEN-1:0]        b;
        logic signed [XLEN-1:0] sra;
        logic [4:0]             sh;
        logic                   ok;
        logic                   alt;
        rd  = w.r.rd;
        a   = model_regs[w.r.rs1];
        b   = model_regs[w.r.rs2];
        res = '0;
        if (w.r.opcode == OPC_OP) begin
            ok = (w.r.funct7 == 7'h00) ||
                 (w.r.funct7 == 7'h20 && (w.r.funct3 == F3_ADD_SUB || w.r.funct3 == F3_SR));
        end else if (w.r.opcode == OPC_OP_IMM) begin
            // Immediate takes the place of rs2
            b = {{20{w.i.imm12[11]}}, w.i.imm12};
            case (w.i.funct3)
                F3_SLL:  ok = (w.i.imm12[11:5] == 7'h00);
                F3_SR:   ok = (w.i.imm12[11:5] == 7'h00) || (w.i.imm12[11:5] == 7'h20);
                default: ok = 1'b1;
            endcase
        end else begin
            ok = (w.r.opcode == OPC_LUI);
        end
        // Instruction bit 30 picks SUB, SRA and SRAI
        alt = w.r.funct7[5] && (w.r.opcode == OPC_OP || w.i.funct3 == F3_SR);
        sh  = b[4:0];
        sra = $signed(a) >>> sh;
        case (w.r.funct3)
            F3_ADD_SUB: res = alt ? a - b : a + b;
            F3_SLL:     res = a << sh;
            F3_SLT:     res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU:    res = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:     res = a ^ b;
            F3_SR:      res = alt ? sra : a >> sh;
            F3_OR:      res = a | b;
            default:    res = a & b;
        endcase
        if (w.r.opcode == OPC_LUI) begin
            res = {w.u.imm20, 12'h000};
        end
        return ok;
    endfunction

    function automatic logic [XLEN-1:0] make_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                                  input logic [11:0] imm);
        return {imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM};
    endfunction

    // Random legal OP, OP-IMM or LUI word
    function automatic logic [XLEN-1:0] rand_legal();
        instr_u     w;
        int         kind;
        logic [2:0] f3;
        w    = $urandom;
        kind = $urandom_range(2, 0);
        f3   = w.r.funct3;
        if (kind == 0) begin
            w.r.opcode = OPC_OP;
            w.r.funct7 = F7_BASE;
            if ((f3 == F3_ADD_SUB || f3 == F3_SR) && $urandom_range(1, 0) == 1) begin
                w.r.funct7 = F7_ALT;
            end
        end else if (kind == 1) begin
            w.i.opcode = OPC_OP_IMM;
            if (f3 == F3_SLL || f3 == F3_SR) begin
                w.i.imm12[11:5] = ($urandom_range(1, 0) == 1 && f3 == F3_SR) ? F7_ALT : F7_BASE;
            end
        end else begin
            w.u.opcode = OPC_LUI;
        end
        return w;
    endfunction

    // Unknown opcode, bad OP funct7 or bad shift-immediate upper bits
    function automatic logic [XLEN-1:0] rand_illegal();
        instr_u                w;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       res;
        logic                  ok;
        do begin
            w = $urandom;
            case ($urandom_range(2, 0))
                0: w.r.opcode = OPC_OP;
                1: begin
                    w.i.opcode = OPC_OP_IMM;
                    w.i.funct3 = ($urandom_range(1, 0) == 1) ? F3_SLL : F3_SR;
                end
                default: ;
            endcase
            ok = model_exec(w, rd, res);
        end while (ok);
        return w;
    endfunction

    task automatic drive_instr(input logic [XLEN-1:0] word);
        logic                  ok;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       res;
        @(posedge clk);
        #2;
        instr_valid_i = 1'b1;
        instr_i       = word;
        ok            = model_exec(word, rd, res);
        cur_legal     = ok;
        cur_illegal   = !ok;
        if (ok) begin
            wb_q.push_back({rd, res});
            // x0 never changes
            if (rd != 5'd0) begin
                model_regs[rd] = res;
            end
        end
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #2;
        instr_valid_i = 1'b0;
        instr_i       = $urandom;
        cur_legal     = 1'b0;
        cur_illegal   = 1'b0;
    endtask

    // Sampled mid-cycle, illegal belongs to this cycle and writeback to the last one
    always @(negedge clk) begin
        if (!rst) begin
            check_flag("illegal_o", cur_illegal, illegal_o);
            check_flag("wb_valid_o", wb_due, wb_valid_o);
            if (wb_due) begin
                wb_exp = wb_q.pop_front();
                check_rd("wb_rd_o", wb_exp.rd, wb_rd_o);
                check_data("wb_data_o", wb_exp.data, wb_data_o);
            end
            wb_due = cur_legal;
        end
    end

    initial begin
        instr_u                w;
        logic [REG_ADDR_W-1:0] prev_rd;
        int                    total;
        rst           = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cur_legal     = 1'b0;
        cur_illegal   = 1'b0;
        wb_due        = 1'b0;
        void'($urandom(32'h7527));
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        model_regs[2] = SP_VAL;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // Reset contents read back through ADDI x0, xN, 0
        for (int r = 0; r < 32; r++) begin
            drive_instr(make_addi(5'd0, r[4:0], 12'h000));
        end
        repeat (N_RANDOM) begin
            drive_instr(rand_legal());
            repeat ($urandom_range(3, 0)) drive_idle();
        end
        // Each source taken from the previous destination, issued back to back
        prev_rd = 5'd1;
        for (int n = 0; n < N_CHAIN; n++) begin
            w       = rand_legal();
            w.r.rs1 = prev_rd;
            if ($urandom_range(1, 0) == 1) begin
                w.r.rs2 = prev_rd;
            end
            w.r.rd  = 5'($urandom_range(31, 1));
            prev_rd = w.r.rd;
            drive_instr(w);
        end
        // Write x0, then read it on the very next cycle
        repeat (N_ZERO) begin
            w      = rand_legal();
            w.r.rd = 5'd0;
            drive_instr(w);
            drive_instr(make_addi(5'($urandom_range(31, 1)), 5'd0, 12'($urandom)));
        end
        // Legal follower shows that the illegal word left no trace
        repeat (N_ILLEGAL) begin
            drive_instr(rand_illegal());
            drive_instr(rand_legal());
        end
        repeat (4) drive_idle();

        total = err_count + u_dut.u_sva.fail_count;
        if (wb_q.size() != 0) begin
            $display("%0d expected writebacks never arrived", wb_q.size());
            total++;
        end
        $display("checks %0d errors %0d", check_count, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: build.f
rv_pkg.sv
issue_if.sv
register_file.sv
instr_decoder.sv
exec_stage.sv
exec_core.sv
exec_core_sva.sv
tb_exec_core.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the exec_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
    --top-module tb_exec_core -f build.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_exec_core)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Done: no errors"; then
    exit 0
fi
exit 1
